// ==== source/exe_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Datapath widths, data types and architectural constants of the
// execute stage. Referenced with scoped names by every RTL file.
//////////////////////////////////////////////////////////////////////

`default_nettype none

package exe_pkg;

   // Architectural widths
   localparam int XLEN          = 32;
   localparam int RF_AWIDTH     = 5;
   localparam int SHAMT_W       = 5;

   // Redirect targets are word aligned
   localparam int PC_ALIGN_BITS = 2;

   // Data word
   typedef logic [XLEN-1:0]      xlen_t;

   // Register file index
   typedef logic [RF_AWIDTH-1:0] reg_addr_t;

   // Shift amount taken from operand 2
   typedef logic [SHAMT_W-1:0]   shamt_t;

   // Comparator difference, MSB is the borrow
   typedef logic [XLEN:0]        cmp_t;

endpackage : exe_pkg

`default_nettype wire

// ==== source/exe_ops_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Operation and operand-select encodings handed from decode to the
// execute stage. Codes not listed in alu_op_e give a zero result.
//////////////////////////////////////////////////////////////////////

`default_nettype none

package exe_ops_pkg;

   localparam int ALU_OP_W = 4;
   localparam int BR_OP_W  = 3;

   //////////////////////////////////////////////////////////////////////
   // ALU operations
   //////////////////////////////////////////////////////////////////////
   typedef enum logic [ALU_OP_W-1:0] {
      ALU_OP_ADD       = 4'd0,
      ALU_OP_SUB       = 4'd1,
      ALU_OP_AND       = 4'd2,
      ALU_OP_OR        = 4'd3,
      ALU_OP_XOR       = 4'd4,
      ALU_OP_SLL       = 4'd5,
      ALU_OP_SRL       = 4'd6,
      ALU_OP_SRA       = 4'd7,
      ALU_OP_COPY_OPR1 = 4'd8,
      ALU_OP_COPY_OPR2 = 4'd9,
      ALU_OP_SLT       = 4'd10,
      ALU_OP_SLTU      = 4'd11
   } alu_op_e;

   // Branch conditions, NONE never takes
   typedef enum logic [BR_OP_W-1:0] {
      BR_OP_NONE = 3'd0,
      BR_OP_EQ   = 3'd1,
      BR_OP_NE   = 3'd2,
      BR_OP_LT   = 3'd3,
      BR_OP_GE   = 3'd4,
      BR_OP_LTU  = 3'd5,
      BR_OP_GEU  = 3'd6
   } br_op_e;

   //////////////////////////////////////////////////////////////////////
   // Operand selects
   //////////////////////////////////////////////////////////////////////
   typedef enum logic {
      OPR1_SEL_REG = 1'b0,
      OPR1_SEL_PC  = 1'b1
   } opr1_sel_e;

   typedef enum logic {
      OPR2_SEL_REG = 1'b0,
      OPR2_SEL_IMM = 1'b1
   } opr2_sel_e;

   typedef enum logic {
      CMP_OPR2_SEL_REG = 1'b0,
      CMP_OPR2_SEL_IMM = 1'b1
   } cmp_opr2_sel_e;

endpackage : exe_ops_pkg

`default_nettype wire

// ==== source/exe_operand_if.sv ====
//////////////////////////////////////////////////////////////////////
// Operands from operand selection to the ALU and comparator.
// No handshake, values are meaningful while valid_i is high.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface exe_operand_if;

   // ALU operands
   exe_pkg::xlen_t opr1;
   exe_pkg::xlen_t opr2;

   // Comparator operands, rs1 against rs2 or the immediate
   exe_pkg::xlen_t cmp_opr1;
   exe_pkg::xlen_t cmp_opr2;

   modport src (
      output opr1,
      output opr2,
      output cmp_opr1,
      output cmp_opr2
   );

   modport dst (
      input opr1,
      input opr2,
      input cmp_opr1,
      input cmp_opr2
   );

endinterface : exe_operand_if

`default_nettype wire

// ==== source/exe_operand_select.sv ====
//////////////////////////////////////////////////////////////////////
// Input side of the execute stage. Forwards the writeback value into
// rs1/rs2 and picks the ALU and comparator operands. Combinational.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module exe_operand_select (
   input  exe_pkg::xlen_t                pc_i,
   input  exe_pkg::xlen_t                imm_i,
   input  exe_pkg::xlen_t                rs1_data_i,
   input  exe_pkg::xlen_t                rs2_data_i,
   input  exe_pkg::xlen_t                wrb_rd_data_i,
   input  logic                          fwd_wrb_rs1_i,
   input  logic                          fwd_wrb_rs2_i,
   input  exe_ops_pkg::opr1_sel_e        opr1_sel_i,
   input  exe_ops_pkg::opr2_sel_e        opr2_sel_i,
   input  exe_ops_pkg::cmp_opr2_sel_e    cmp_opr2_sel_i,
   exe_operand_if.src                    opr,
   output exe_pkg::xlen_t                rs2_fwd_o
);

   exe_pkg::xlen_t rs1_fwd;
   exe_pkg::xlen_t rs2_fwd;

   // Writeback forwarding
   assign rs1_fwd = fwd_wrb_rs1_i ? wrb_rd_data_i : rs1_data_i;
   assign rs2_fwd = fwd_wrb_rs2_i ? wrb_rd_data_i : rs2_data_i;

   // ALU operands
   assign opr.opr1 = (opr1_sel_i == exe_ops_pkg::OPR1_SEL_PC) ? pc_i : rs1_fwd;
   assign opr.opr2 = (opr2_sel_i == exe_ops_pkg::OPR2_SEL_IMM) ? imm_i : rs2_fwd;

   // Comparator always sees rs1, and rs2 or the immediate for slti/sltiu
   assign opr.cmp_opr1 = rs1_fwd;
   assign opr.cmp_opr2 = (cmp_opr2_sel_i == exe_ops_pkg::CMP_OPR2_SEL_IMM) ? imm_i : rs2_fwd;

   // Store data leaves with the forwarded value
   assign rs2_fwd_o = rs2_fwd;

   // An unknown select would silently route X into the ALU and the stage register
   always_comb begin
      assert (!$isunknown({opr1_sel_i, opr2_sel_i, cmp_opr2_sel_i}))
         else $error("operand select is unknown");
   end

endmodule : exe_operand_select

`default_nettype wire

// ==== source/exe_alu.sv ====
//////////////////////////////////////////////////////////////////////
// Processing part of the execute stage. Base RV32I ALU with one
// shared adder, plus the comparator that feeds slt/sltu and all six
// branch conditions. Purely combinational.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module exe_alu (
   exe_operand_if.dst             opr,
   input  exe_ops_pkg::alu_op_e   alu_op_i,
   input  exe_ops_pkg::br_op_e    br_op_i,
   output exe_pkg::xlen_t         alu_result_o,
   output logic                   branch_taken_o
);

   localparam int MSB = exe_pkg::XLEN - 1;

   exe_pkg::xlen_t  adder_opr2;
   exe_pkg::xlen_t  adder_out;
   logic            is_sub;
   exe_pkg::shamt_t shamt;

   exe_pkg::cmp_t   cmp_diff;
   logic            cmp_zero;
   logic            cmp_neg;
   logic            cmp_ovf;
   logic            cmp_borrow;
   logic            cmp_lt;

   //////////////////////////////////////////////////////////////////////
   // Shared adder
   //////////////////////////////////////////////////////////////////////

   // Subtract as opr1 + ~opr2 + 1
   assign is_sub     = (alu_op_i == exe_ops_pkg::ALU_OP_SUB);
   assign adder_opr2 = is_sub ? ~opr.opr2 : opr.opr2;
   assign adder_out  = opr.opr1 + adder_opr2 + exe_pkg::xlen_t'(is_sub);

   // Only the low bits of operand 2 shift
   assign shamt = opr.opr2[exe_pkg::SHAMT_W-1:0];

   //////////////////////////////////////////////////////////////////////
   // Comparator
   //////////////////////////////////////////////////////////////////////

   // Zero-extended subtract, bit XLEN is the borrow
   assign cmp_diff   = {1'b0, opr.cmp_opr1} - {1'b0, opr.cmp_opr2};
   assign cmp_zero   = ~|cmp_diff[MSB:0];
   assign cmp_neg    = cmp_diff[MSB];
   assign cmp_borrow = cmp_diff[exe_pkg::XLEN];

   // Overflow when the signs differ and the result sign follows opr2
   assign cmp_ovf = (opr.cmp_opr1[MSB] ^ opr.cmp_opr2[MSB]) & (cmp_neg ^ opr.cmp_opr1[MSB]);
   assign cmp_lt  = cmp_neg ^ cmp_ovf;

   always_comb begin
      case (br_op_i)
         exe_ops_pkg::BR_OP_EQ:  branch_taken_o = cmp_zero;
         exe_ops_pkg::BR_OP_NE:  branch_taken_o = ~cmp_zero;
         exe_ops_pkg::BR_OP_LT:  branch_taken_o = cmp_lt;
         exe_ops_pkg::BR_OP_GE:  branch_taken_o = ~cmp_lt;
         exe_ops_pkg::BR_OP_LTU: branch_taken_o = cmp_borrow;
         exe_ops_pkg::BR_OP_GEU: branch_taken_o = ~cmp_borrow;
         default:                branch_taken_o = 1'b0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Result select
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      case (alu_op_i)
         exe_ops_pkg::ALU_OP_ADD,
         exe_ops_pkg::ALU_OP_SUB: begin
            alu_result_o = adder_out;
         end
         exe_ops_pkg::ALU_OP_AND:       alu_result_o = opr.opr1 & opr.opr2;
         exe_ops_pkg::ALU_OP_OR:        alu_result_o = opr.opr1 | opr.opr2;
         exe_ops_pkg::ALU_OP_XOR:       alu_result_o = opr.opr1 ^ opr.opr2;
         exe_ops_pkg::ALU_OP_SLL:       alu_result_o = opr.opr1 << shamt;
         exe_ops_pkg::ALU_OP_SRL:       alu_result_o = opr.opr1 >> shamt;
         exe_ops_pkg::ALU_OP_SRA: begin
            alu_result_o = exe_pkg::xlen_t'($signed(opr.opr1) >>> shamt);
         end
         // jal/jalr link and auipc go through operand 1, lui through operand 2
         exe_ops_pkg::ALU_OP_COPY_OPR1: alu_result_o = opr.opr1;
         exe_ops_pkg::ALU_OP_COPY_OPR2: alu_result_o = opr.opr2;
         exe_ops_pkg::ALU_OP_SLT:       alu_result_o = exe_pkg::xlen_t'(cmp_lt);
         exe_ops_pkg::ALU_OP_SLTU:      alu_result_o = exe_pkg::xlen_t'(cmp_borrow);
         default:                       alu_result_o = '0;
      endcase
   end

   // A non-branch must never raise a redirect further down
   always_comb begin
      if (br_op_i == exe_ops_pkg::BR_OP_NONE) begin
         assert (!branch_taken_o)
            else $error("branch taken without a branch operation");
      end
   end

endmodule : exe_alu

`default_nettype wire

// ==== source/exe_result_stage.sv ====
//////////////////////////////////////////////////////////////////////
// Output side of the execute stage. One register stage toward memory
// holding the result, store data, destination and fetch redirect.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module exe_result_stage (
   input  logic                  clk,
   input  logic                  reset_i,
   input  logic                  valid_i,
   input  exe_pkg::xlen_t        alu_result_i,
   input  exe_pkg::xlen_t        rs2_fwd_i,
   input  exe_pkg::reg_addr_t    rd_addr_i,
   input  logic                  rd_wr_req_i,
   input  logic                  jump_req_i,
   input  logic                  branch_req_i,
   input  logic                  branch_taken_i,
   output logic                  valid_o,
   output exe_pkg::xlen_t        alu_result_o,
   output exe_pkg::xlen_t        store_data_o,
   output exe_pkg::reg_addr_t    rd_addr_o,
   output logic                  rd_wr_req_o,
   output logic                  redirect_o,
   output exe_pkg::xlen_t        pc_new_o
);

   logic           redirect_req;
   exe_pkg::xlen_t pc_target;

   // Jumps always redirect, branches only when the condition holds
   assign redirect_req = valid_i & (jump_req_i | (branch_req_i & branch_taken_i));

   // Clear the low bits so fetch sees a word address
   assign pc_target = {alu_result_i[exe_pkg::XLEN-1:exe_pkg::PC_ALIGN_BITS],
                       {exe_pkg::PC_ALIGN_BITS{1'b0}}};

   //////////////////////////////////////////////////////////////////////
   // Control
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset_i) begin
         valid_o     <= 1'b0;
         rd_wr_req_o <= 1'b0;
         redirect_o  <= 1'b0;
      end else begin
         valid_o     <= valid_i;
         rd_wr_req_o <= valid_i & rd_wr_req_i;
         redirect_o  <= redirect_req;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Payload, held while idle
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (valid_i) begin
         alu_result_o <= alu_result_i;
         store_data_o <= rs2_fwd_i;
         rd_addr_o    <= rd_addr_i;
         pc_new_o     <= pc_target;
      end
   end

   // Memory and fetch act on these strobes only for a real instruction
   assert property (@(posedge clk) disable iff (reset_i)
                    (redirect_o || rd_wr_req_o) |-> valid_o)
      else $error("redirect or register write without valid");

endmodule : exe_result_stage

`default_nettype wire

// ==== source/exe_top.sv ====
//////////////////////////////////////////////////////////////////////
// Execute stage top level. Decode drives the plain inputs, results
// appear one cycle later toward memory and fetch.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module exe_top (
   input  logic                          clk,
   input  logic                          reset_i,
   input  logic                          valid_i,
   input  exe_pkg::xlen_t                pc_i,
   input  exe_pkg::xlen_t                imm_i,
   input  exe_pkg::xlen_t                rs1_data_i,
   input  exe_pkg::xlen_t                rs2_data_i,
   input  exe_pkg::xlen_t                wrb_rd_data_i,
   input  logic                          fwd_wrb_rs1_i,
   input  logic                          fwd_wrb_rs2_i,
   input  exe_ops_pkg::alu_op_e          alu_op_i,
   input  exe_ops_pkg::br_op_e           br_op_i,
   input  exe_ops_pkg::opr1_sel_e        opr1_sel_i,
   input  exe_ops_pkg::opr2_sel_e        opr2_sel_i,
   input  exe_ops_pkg::cmp_opr2_sel_e    cmp_opr2_sel_i,
   input  logic                          jump_req_i,
   input  logic                          branch_req_i,
   input  exe_pkg::reg_addr_t            rd_addr_i,
   input  logic                          rd_wr_req_i,
   output logic                          valid_o,
   output exe_pkg::xlen_t                alu_result_o,
   output exe_pkg::xlen_t                store_data_o,
   output exe_pkg::reg_addr_t            rd_addr_o,
   output logic                          rd_wr_req_o,
   output logic                          redirect_o,
   output exe_pkg::xlen_t                pc_new_o
);

   exe_pkg::xlen_t rs2_fwd;
   exe_pkg::xlen_t alu_result;
   logic           branch_taken;

   exe_operand_if opr_if ();

   // Input side
   exe_operand_select operand_select_i (
      .pc_i           (pc_i),
      .imm_i          (imm_i),
      .rs1_data_i     (rs1_data_i),
      .rs2_data_i     (rs2_data_i),
      .wrb_rd_data_i  (wrb_rd_data_i),
      .fwd_wrb_rs1_i  (fwd_wrb_rs1_i),
      .fwd_wrb_rs2_i  (fwd_wrb_rs2_i),
      .opr1_sel_i     (opr1_sel_i),
      .opr2_sel_i     (opr2_sel_i),
      .cmp_opr2_sel_i (cmp_opr2_sel_i),
      .opr            (opr_if.src),
      .rs2_fwd_o      (rs2_fwd)
   );

   // ALU and branch compare
   exe_alu alu_i (
      .opr            (opr_if.dst),
      .alu_op_i       (alu_op_i),
      .br_op_i        (br_op_i),
      .alu_result_o   (alu_result),
      .branch_taken_o (branch_taken)
   );

   // Stage register toward memory
   exe_result_stage result_stage_i (
      .clk            (clk),
      .reset_i        (reset_i),
      .valid_i        (valid_i),
      .alu_result_i   (alu_result),
      .rs2_fwd_i      (rs2_fwd),
      .rd_addr_i      (rd_addr_i),
      .rd_wr_req_i    (rd_wr_req_i),
      .jump_req_i     (jump_req_i),
      .branch_req_i   (branch_req_i),
      .branch_taken_i (branch_taken),
      .valid_o        (valid_o),
      .alu_result_o   (alu_result_o),
      .store_data_o   (store_data_o),
      .rd_addr_o      (rd_addr_o),
      .rd_wr_req_o    (rd_wr_req_o),
      .redirect_o     (redirect_o),
      .pc_new_o       (pc_new_o)
   );

endmodule : exe_top

`default_nettype wire

// ==== bench/exe_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the execute stage. Replays the trace file through
// the DUT, one line per cycle with random idle gaps, and compares the
// registered outputs one cycle later.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module exe_tb;

   localparam int MAX_LINES = 64;
   localparam int N_FIELDS  = 21;

   // Trace columns
   localparam int F_VALID  = 0;
   localparam int F_PC     = 1;
   localparam int F_IMM    = 2;
   localparam int F_RS1    = 3;
   localparam int F_RS2    = 4;
   localparam int F_WRB    = 5;
   localparam int F_FWD1   = 6;
   localparam int F_FWD2   = 7;
   localparam int F_ALU_OP = 8;
   localparam int F_BR_OP  = 9;
   localparam int F_SEL1   = 10;
   localparam int F_SEL2   = 11;
   localparam int F_CSEL   = 12;
   localparam int F_JUMP   = 13;
   localparam int F_BRANCH = 14;
   localparam int F_RD     = 15;
   localparam int F_RD_WR  = 16;
   localparam int F_RESULT = 17;
   localparam int F_STORE  = 18;
   localparam int F_REDIR  = 19;
   localparam int F_PC_NEW = 20;

   logic clk;
   logic reset_i;
   logic valid_i;
   exe_pkg::xlen_t pc_i;
   exe_pkg::xlen_t imm_i;
   exe_pkg::xlen_t rs1_data_i;
   exe_pkg::xlen_t rs2_data_i;
   exe_pkg::xlen_t wrb_rd_data_i;
   logic fwd_wrb_rs1_i;
   logic fwd_wrb_rs2_i;
   exe_ops_pkg::alu_op_e alu_op_i;
   exe_ops_pkg::br_op_e br_op_i;
   exe_ops_pkg::opr1_sel_e opr1_sel_i;
   exe_ops_pkg::opr2_sel_e opr2_sel_i;
   exe_ops_pkg::cmp_opr2_sel_e cmp_opr2_sel_i;
   logic jump_req_i;
   logic branch_req_i;
   exe_pkg::reg_addr_t rd_addr_i;
   logic rd_wr_req_i;
   logic valid_o;
   exe_pkg::xlen_t alu_result_o;
   exe_pkg::xlen_t store_data_o;
   exe_pkg::reg_addr_t rd_addr_o;
   logic rd_wr_req_o;
   logic redirect_o;
   exe_pkg::xlen_t pc_new_o;

   logic [31:0] trace_mem [0:MAX_LINES-1][0:N_FIELDS-1];
   int n_lines = 0;
   bit loaded = 0;
   int n_tests = 0;
   int n_failed = 0;
   // Trace line whose result is due (-1 for an idle cycle, -2 when none is)
   int pend_idx = -2;

   exe_top exe_top_i (.*);

   always #4 clk = ~clk;

   ///////////////////////////////////////////////////////////////////////
   // Trace reading and driving
   ///////////////////////////////////////////////////////////////////////
   task automatic load_trace(output bit ok);
      int fd;
      int cnt;
      string line;
      logic [31:0] v [0:N_FIELDS-1];
      ok = 1'b0;
      fd = $fopen("bench/exe_trace.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd) && n_lines < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
               cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                             v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17],
                             v[18], v[19], v[20]);
               if (cnt == N_FIELDS) begin
                  for (int f = 0; f < N_FIELDS; f++) begin
                     trace_mem[n_lines][f] = v[f];
                  end
                  n_lines++;
               end
            end
         end
         $fclose(fd);
         ok = (n_lines > 0);
      end
   endtask

   task automatic drive_line(input int i);
      valid_i        <= trace_mem[i][F_VALID][0];
      pc_i           <= trace_mem[i][F_PC];
      imm_i          <= trace_mem[i][F_IMM];
      rs1_data_i     <= trace_mem[i][F_RS1];
      rs2_data_i     <= trace_mem[i][F_RS2];
      wrb_rd_data_i  <= trace_mem[i][F_WRB];
      fwd_wrb_rs1_i  <= trace_mem[i][F_FWD1][0];
      fwd_wrb_rs2_i  <= trace_mem[i][F_FWD2][0];
      alu_op_i       <= exe_ops_pkg::alu_op_e'(
                           trace_mem[i][F_ALU_OP][exe_ops_pkg::ALU_OP_W-1:0]);
      br_op_i        <= exe_ops_pkg::br_op_e'(
                           trace_mem[i][F_BR_OP][exe_ops_pkg::BR_OP_W-1:0]);
      opr1_sel_i     <= exe_ops_pkg::opr1_sel_e'(trace_mem[i][F_SEL1][0]);
      opr2_sel_i     <= exe_ops_pkg::opr2_sel_e'(trace_mem[i][F_SEL2][0]);
      cmp_opr2_sel_i <= exe_ops_pkg::cmp_opr2_sel_e'(trace_mem[i][F_CSEL][0]);
      jump_req_i     <= trace_mem[i][F_JUMP][0];
      branch_req_i   <= trace_mem[i][F_BRANCH][0];
      rd_addr_i      <= trace_mem[i][F_RD][4:0];
      rd_wr_req_i    <= trace_mem[i][F_RD_WR][0];
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Checks
   ///////////////////////////////////////////////////////////////////////
   task automatic compare(input string what, input logic [31:0] got,
                          input logic [31:0] exp, inout bit ok);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         ok = 1'b0;
      end
   endtask

   task automatic check_idle(input string name);
      bit ok;
      ok = 1'b1;
      compare("valid_o", 32'(valid_o), 32'd0, ok);
      compare("rd_wr_req_o", 32'(rd_wr_req_o), 32'd0, ok);
      compare("redirect_o", 32'(redirect_o), 32'd0, ok);
      n_tests++;
      if (!ok) n_failed++;
      $display("%s: %s", name, ok ? "ok" : "mismatch");
   endtask

   task automatic check_pending();
      bit ok;
      int i;
      i = pend_idx;
      ok = 1'b1;
      if (i == -1) begin
         check_idle("idle cycle");
      end else if (i >= 0) begin
         if (!trace_mem[i][F_VALID][0]) begin
            check_idle($sformatf("trace line %0d (idle)", i));
         end else begin
            compare("valid_o", 32'(valid_o), 32'd1, ok);
            compare("rd_wr_req_o", 32'(rd_wr_req_o), 32'(trace_mem[i][F_RD_WR][0]), ok);
            compare("rd_addr_o", 32'(rd_addr_o), 32'(trace_mem[i][F_RD][4:0]), ok);
            compare("alu_result_o", alu_result_o, trace_mem[i][F_RESULT], ok);
            compare("store_data_o", store_data_o, trace_mem[i][F_STORE], ok);
            compare("redirect_o", 32'(redirect_o), 32'(trace_mem[i][F_REDIR][0]), ok);
            compare("pc_new_o", pc_new_o, trace_mem[i][F_PC_NEW], ok);
            n_tests++;
            if (!ok) n_failed++;
            $display("trace line %0d: %s", i, ok ? "ok" : "mismatch");
         end
      end
   endtask

   // Result of the previous cycle's input is visible at the falling edge
   task automatic step(input int next_idx);
      @(posedge clk);
      if (next_idx >= 0) drive_line(next_idx);
      else valid_i <= 1'b0;
      @(negedge clk);
      check_pending();
      pend_idx = next_idx;
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Main sequence
   ///////////////////////////////////////////////////////////////////////
   initial begin
      bit ok;
      clk = 1'b0;
      reset_i = 1'b1;
      // Strobes stay high through reset so that only reset_i can keep the outputs low
      valid_i = 1'b1;
      pc_i = '0;
      imm_i = '0;
      rs1_data_i = '0;
      rs2_data_i = '0;
      wrb_rd_data_i = '0;
      fwd_wrb_rs1_i = 1'b0;
      fwd_wrb_rs2_i = 1'b0;
      alu_op_i = exe_ops_pkg::ALU_OP_ADD;
      br_op_i = exe_ops_pkg::BR_OP_NONE;
      opr1_sel_i = exe_ops_pkg::OPR1_SEL_REG;
      opr2_sel_i = exe_ops_pkg::OPR2_SEL_REG;
      cmp_opr2_sel_i = exe_ops_pkg::CMP_OPR2_SEL_REG;
      jump_req_i = 1'b1;
      branch_req_i = 1'b0;
      rd_addr_i = '0;
      rd_wr_req_i = 1'b1;
      void'($urandom(60613));
      load_trace(ok);
      loaded = 1'b1;
      if (!ok) begin
         $display("Could not read any line from bench/exe_trace.txt");
         $display("Some tests failed");
         $finish;
      end else begin
         repeat (4) @(posedge clk);
         reset_i <= 1'b0;
         valid_i <= 1'b0;
         jump_req_i <= 1'b0;
         rd_wr_req_i <= 1'b0;
         @(negedge clk);
         check_idle("reset");
         for (int i = 0; i < n_lines; i++) begin
            step(i);
            if (($urandom % 4) == 0) step(-1);
         end
         step(-1);
         step(-1);
         $display("%0d tests run, %0d failed", n_tests, n_failed);
         if (n_failed == 0) begin
            $display("All tests passed");
         end else begin
            $display("Some tests failed");
         end
         $finish;
      end
   end

   // Watchdog sized from the trace length
   initial begin
      wait (loaded);
      repeat (n_lines * 10 + 100) @(posedge clk);
      $display("Run timed out before the trace was finished");
      $display("Some tests failed");
      $finish;
   end

endmodule : exe_tb

`default_nettype wire

// ==== bench/exe_trace.txt ====
# valid pc imm rs1 rs2 wrb fwd1 fwd2 alu_op br_op sel1 sel2 cmp_sel jump branch rd rd_wr
# then expected: alu_result store_data redirect pc_new (all hex)
1 00001000 00000000 00000005 00000007 00000000 0 0 0 0 0 0 0 0 0 01 1 0000000c 00000007 0 0000000c
1 00001000 00000002 ffffffff 00000000 00000000 0 0 0 0 0 1 0 0 0 02 1 00000001 00000000 0 00000000
1 00001000 00000000 00000003 00000005 00000000 0 0 1 0 0 0 0 0 0 03 1 fffffffe 00000005 0 fffffffc
1 00001000 00000000 80000000 00000001 00000000 0 0 1 0 0 0 0 0 0 04 1 7fffffff 00000001 0 7ffffffc
1 00001000 00000000 f0f0f0f0 0ff00ff0 00000000 0 0 2 0 0 0 0 0 0 05 1 00f000f0 0ff00ff0 0 00f000f0
1 00001000 00005678 12340000 00000000 00000000 0 0 3 0 0 1 0 0 0 06 1 12345678 00000000 0 12345678
1 00001000 00000000 aaaaaaaa ffffffff 00000000 0 0 4 0 0 0 0 0 0 07 1 55555555 ffffffff 0 55555554
1 00001000 00000000 00000001 00000024 00000000 0 0 5 0 0 0 0 0 0 08 1 00000010 00000024 0 00000010
1 00001000 0000003f 80000000 00000000 00000000 0 0 6 0 0 1 0 0 0 09 1 00000001 00000000 0 00000000
1 00001000 00000000 80000000 00000004 00000000 0 0 7 0 0 0 0 0 0 0a 1 f8000000 00000004 0 f8000000
1 00002004 00000000 00000000 00000000 00000000 0 0 8 0 1 0 0 0 0 0b 1 00002004 00000000 0 00002004
1 00001000 12345000 00000000 00000000 00000000 0 0 9 0 0 1 0 0 0 0c 1 12345000 00000000 0 12345000
1 00001000 00000000 ffffffff 00000001 00000000 0 0 a 0 0 0 0 0 0 0d 1 00000001 00000001 0 00000000
1 00001000 00000000 ffffffff 00000001 00000000 0 0 b 0 0 0 0 0 0 0e 1 00000000 00000001 0 00000000
1 00001000 00000007 00000007 00000000 00000000 0 0 a 0 0 1 1 0 0 0f 1 00000000 00000000 0 00000000
1 00001000 00000002 00000001 00000000 00000000 0 0 b 0 0 1 1 0 0 10 1 00000001 00000000 0 00000000
1 00001000 00000000 00000005 00000005 00000000 0 0 f 0 0 0 0 0 0 11 1 00000000 00000005 0 00000000
1 00001000 00000010 00000005 00000005 00000000 0 0 0 1 1 1 0 0 1 00 0 00001010 00000005 1 00001010
1 00001000 00000010 00000005 00000006 00000000 0 0 0 1 1 1 0 0 1 00 0 00001010 00000006 0 00001010
1 00001000 00000010 00000005 00000006 00000000 0 0 0 2 1 1 0 0 1 00 0 00001010 00000006 1 00001010
1 00001000 00000010 00000005 00000005 00000000 0 0 0 2 1 1 0 0 1 00 0 00001010 00000005 0 00001010
1 00001000 00000010 ffffffff 00000001 00000000 0 0 0 3 1 1 0 0 1 00 0 00001010 00000001 1 00001010
1 00001000 00000010 00000001 ffffffff 00000000 0 0 0 3 1 1 0 0 1 00 0 00001010 ffffffff 0 00001010
1 00001000 00000010 00000001 ffffffff 00000000 0 0 0 4 1 1 0 0 1 00 0 00001010 ffffffff 1 00001010
1 00001000 00000010 ffffffff 00000001 00000000 0 0 0 4 1 1 0 0 1 00 0 00001010 00000001 0 00001010
1 00001000 00000010 00000001 ffffffff 00000000 0 0 0 5 1 1 0 0 1 00 0 00001010 ffffffff 1 00001010
1 00001000 00000010 ffffffff 00000001 00000000 0 0 0 5 1 1 0 0 1 00 0 00001010 00000001 0 00001010
1 00001000 00000010 ffffffff 00000001 00000000 0 0 0 6 1 1 0 0 1 00 0 00001010 00000001 1 00001010
1 00001000 00000010 00000001 ffffffff 00000000 0 0 0 6 1 1 0 0 1 00 0 00001010 ffffffff 0 00001010
1 00002000 00000007 00000000 00000000 00000000 0 0 0 0 1 1 0 1 0 01 1 00002007 00000000 1 00002004
1 00001000 00000000 00000001 00000002 00000100 1 0 0 0 0 0 0 0 0 12 1 00000102 00000002 0 00000100
1 00001000 00000000 00000001 00000002 00000100 0 1 0 0 0 0 0 0 0 13 1 00000101 00000100 0 00000100
0 00000000 00000000 00000000 00000000 00000000 0 0 0 0 0 0 0 0 0 00 0 00000000 00000000 0 00000000

// ==== tb.f ====
source/exe_pkg.sv
source/exe_ops_pkg.sv
source/exe_operand_if.sv
source/exe_operand_select.sv
source/exe_alu.sv
source/exe_result_stage.sv
source/exe_top.sv
bench/exe_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module exe_tb -o exe_sim

output=$(./obj_dir/exe_sim)
echo "$output"

if echo "$output" | grep -q "All tests passed"; then
   exit 0
else
   exit 1
fi
